// ==== cpu_axi_read.f ====
common/cpu_axi_read_pkg.sv
fetch/fetch_line_reader.sv
lsu/load_reader.sv
logic/axi_read_arbiter.sv
logic/cpu_axi_read_top.sv
dv/tb_axi_mem_model.sv
dv/tb_cpu_axi_read.sv

// ==== Bender.yml ====
package:
  name: cpu_axi_read

sources:
  # Shared package first, then the readers, the arbiter and the top level
  - common/cpu_axi_read_pkg.sv
  - fetch/fetch_line_reader.sv
  - lsu/load_reader.sv
  - logic/axi_read_arbiter.sv
  - logic/cpu_axi_read_top.sv

  # Testbench: memory model and testbench top
  - target: test
    files:
      - dv/tb_axi_mem_model.sv
      - dv/tb_cpu_axi_read.sv

// ==== dv/tb_cpu_axi_read.sv ====
module tb_cpu_axi_read;

	localparam int LINE_BEATS     = 4;
	localparam int SEED           = 7278;
	localparam int CYCLES_PER_REQ = 200;
	localparam int BASE_CYCLES    = 1000;

	typedef logic [LINE_BEATS*64-1:0] line_t;

	logic                    clk;
	logic                    arst_n;
	logic                    fetch_req_valid;
	cpu_axi_read_pkg::addr_t fetch_req_addr;
	logic                    fetch_req_ready;
	logic                    fetch_line_valid;
	line_t                   fetch_line_data;
	logic                    fetch_line_err;
	logic                    fetch_line_ready;
	logic                    load_req_valid;
	cpu_axi_read_pkg::addr_t load_req_addr;
	cpu_axi_read_pkg::size_t load_req_size;
	logic                    load_req_ready;
	logic                    load_resp_valid;
	cpu_axi_read_pkg::data_t load_resp_data;
	logic                    load_resp_err;
	logic                    load_resp_ready;
	logic                    ar_valid;
	cpu_axi_read_pkg::addr_t ar_addr;
	cpu_axi_read_pkg::len_t  ar_len;
	cpu_axi_read_pkg::size_t ar_size;
	logic                    ar_ready;
	logic                    r_valid;
	cpu_axi_read_pkg::data_t r_data;
	cpu_axi_read_pkg::resp_t r_resp;
	logic                    r_last;
	logic                    r_ready;

	// Expected responses in request order
	line_t                   exp_line_q[$];
	bit                      exp_line_err_q[$];
	cpu_axi_read_pkg::data_t exp_load_q[$];
	bit                      exp_load_err_q[$];

	string                   cur_test = "reset";
	int                      checks = 0;
	int                      errors = 0;
	int                      n_tests = 0;
	int                      test_checks = 0;
	int                      test_errors = 0;
	int                      issued = 0;
	int                      cycles = 0;
	logic                    stall_resp = 1'b0;
	logic                    stall_now = 1'b0;
	logic                    watch_ar = 1'b0;
	logic                    line_held = 1'b0;
	logic                    load_held = 1'b0;
	logic [LINE_BEATS*64:0]  held_line;
	logic [64:0]             held_load;
	cpu_axi_read_pkg::addr_t first_ar_addr;
	cpu_axi_read_pkg::len_t  first_ar_len;
	cpu_axi_read_pkg::size_t first_ar_size;

	cpu_axi_read_top #(.LINE_BEATS(LINE_BEATS)) dut (.*);

	tb_axi_mem_model mem (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Each beat of memory holds its own address above its inverse
	function automatic line_t exp_line(input cpu_axi_read_pkg::addr_t addr);
		line_t                   line;
		cpu_axi_read_pkg::addr_t base;
		cpu_axi_read_pkg::addr_t beat_addr;
		int                      i;
		base = addr - (addr % (LINE_BEATS * 8));
		for (i = 0; i < LINE_BEATS; i++) begin
			beat_addr = base + 32'(i * 8);
			line[i*64 +: 64] = {beat_addr, ~beat_addr};
		end
		return line;
	endfunction

	function automatic cpu_axi_read_pkg::data_t exp_load(input cpu_axi_read_pkg::addr_t addr,
			input cpu_axi_read_pkg::size_t size);
		cpu_axi_read_pkg::addr_t beat_addr;
		cpu_axi_read_pkg::data_t beat;
		cpu_axi_read_pkg::data_t val;
		int                      ofs;
		int                      i;
		beat_addr = addr - (addr % 8);
		beat = {beat_addr, ~beat_addr};
		ofs = int'(addr % 8);
		val = '0;
		for (i = 0; i < (1 << size); i++) begin
			val[i*8 +: 8] = beat[(ofs + i)*8 +: 8];
		end
		return val;
	endfunction

	function automatic cpu_axi_read_pkg::addr_t rand_fetch_addr(input bit err);
		cpu_axi_read_pkg::addr_t a;
		a = $urandom();
		a[31] = err;
		return a;
	endfunction

	// Loads are naturally aligned to their size
	function automatic cpu_axi_read_pkg::addr_t rand_load_addr(input cpu_axi_read_pkg::size_t size,
			input bit err);
		cpu_axi_read_pkg::addr_t a;
		a = $urandom();
		a[2:0] = (a[2:0] >> size) << size;
		a[31] = err;
		return a;
	endfunction

	task automatic check_value(input string what, input logic [LINE_BEATS*64:0] exp,
			input logic [LINE_BEATS*64:0] act);
		checks++;
		assert (act === exp) else begin
			$display("ERR %s %s expected %0h actual %0h", cur_test, what, exp, act);
			errors++;
		end
	endtask

	task automatic issue_requests(input bit do_fetch, input cpu_axi_read_pkg::addr_t f_addr,
			input bit do_load, input cpu_axi_read_pkg::addr_t l_addr,
			input cpu_axi_read_pkg::size_t l_size);
		bit f_pend;
		bit l_pend;
		f_pend = do_fetch;
		l_pend = do_load;
		if (do_fetch) begin
			exp_line_q.push_back(exp_line(f_addr));
			exp_line_err_q.push_back(f_addr[31]);
			issued++;
		end
		if (do_load) begin
			exp_load_q.push_back(exp_load(l_addr, l_size));
			exp_load_err_q.push_back(l_addr[31]);
			issued++;
		end
		@(negedge clk);
		fetch_req_valid = do_fetch;
		fetch_req_addr  = f_addr;
		load_req_valid  = do_load;
		load_req_addr   = l_addr;
		load_req_size   = l_size;
		while (f_pend || l_pend) begin
			@(posedge clk);
			if (fetch_req_valid && fetch_req_ready) f_pend = 1'b0;
			if (load_req_valid && load_req_ready) l_pend = 1'b0;
			@(negedge clk);
			if (!f_pend) fetch_req_valid = 1'b0;
			if (!l_pend) load_req_valid = 1'b0;
		end
	endtask

	task automatic wait_drained();
		while (exp_line_q.size() != 0 || exp_load_q.size() != 0) begin
			@(negedge clk);
		end
	endtask

	task automatic begin_test(input string name);
		cur_test    = name;
		test_checks = checks;
		test_errors = errors;
	endtask

	task automatic close_test();
		wait_drained();
		n_tests++;
		$display("%s finished: %0d checks, %0d errors", cur_test, checks - test_checks,
			errors - test_errors);
	endtask

	// Response readies, random while a stall phase is on
	initial begin
		fetch_line_ready = 1'b1;
		load_resp_ready  = 1'b1;
		forever begin
			@(posedge clk);
			stall_now = stall_resp;
			@(negedge clk);
			fetch_line_ready = !stall_now || ($urandom_range(0, 3) == 0);
			load_resp_ready  = !stall_now || ($urandom_range(0, 3) == 0);
		end
	end

	always @(posedge clk) begin
		if (arst_n) begin
			assert (!(fetch_line_valid && fetch_req_ready)) else begin
				$display("%s: fetch reader open for a request while holding a line", cur_test);
				errors++;
			end
			assert (!(load_resp_valid && load_req_ready)) else begin
				$display("%s: load reader open for a request while holding a result", cur_test);
				errors++;
			end
			if (line_held) begin
				check_value("held fetch valid", 1'b1, fetch_line_valid);
				check_value("held fetch line", held_line, {fetch_line_err, fetch_line_data});
			end
			if (load_held) begin
				check_value("held load valid", 1'b1, load_resp_valid);
				check_value("held load data", held_load, {load_resp_err, load_resp_data});
			end
			if (fetch_line_valid && fetch_line_ready) begin
				assert (exp_line_q.size() > 0) else begin
					$display("%s: fetch line returned with no fetch outstanding", cur_test);
					errors++;
				end
				if (exp_line_q.size() > 0) begin
					check_value("fetch line", exp_line_q.pop_front(), fetch_line_data);
					check_value("fetch error", exp_line_err_q.pop_front(), fetch_line_err);
				end
			end
			if (load_resp_valid && load_resp_ready) begin
				assert (exp_load_q.size() > 0) else begin
					$display("%s: load data returned with no load outstanding", cur_test);
					errors++;
				end
				if (exp_load_q.size() > 0) begin
					check_value("load data", exp_load_q.pop_front(), load_resp_data);
					check_value("load error", exp_load_err_q.pop_front(), load_resp_err);
				end
			end
			line_held = fetch_line_valid && !fetch_line_ready;
			held_line = {fetch_line_err, fetch_line_data};
			load_held = load_resp_valid && !load_resp_ready;
			held_load = {load_resp_err, load_resp_data};
			if (watch_ar && ar_valid && ar_ready) begin
				first_ar_addr = ar_addr;
				first_ar_len  = ar_len;
				first_ar_size = ar_size;
				watch_ar      = 1'b0;
			end
		end
	end

	// The limit grows with every request put on the ports
	always @(posedge clk) begin
		cycles++;
		if (cycles > CYCLES_PER_REQ * issued + BASE_CYCLES) begin
			$display("Timeout after %0d cycles, a request or response never completed", cycles);
			$display("Test failed");
			$finish;
		end
	end

	initial begin
		cpu_axi_read_pkg::addr_t a;
		int                      i;
		int                      k;
		int                      kind;
		void'($urandom(SEED));
		arst_n          = 1'b0;
		fetch_req_valid = 1'b0;
		fetch_req_addr  = '0;
		load_req_valid  = 1'b0;
		load_req_addr   = '0;
		load_req_size   = '0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;
		@(negedge clk);

		begin_test("reset_values");
		check_value("ar_valid", 1'b0, ar_valid);
		check_value("r_ready", 1'b0, r_ready);
		check_value("fetch_line_valid", 1'b0, fetch_line_valid);
		check_value("load_resp_valid", 1'b0, load_resp_valid);
		check_value("fetch_req_ready", 1'b1, fetch_req_ready);
		check_value("load_req_ready", 1'b1, load_req_ready);
		close_test();

		begin_test("fetch_unaligned");
		for (i = 0; i < 10; i++) begin
			issue_requests(1'b1, rand_fetch_addr(1'b0), 1'b0, '0, '0);
		end
		close_test();

		begin_test("load_sizes");
		for (k = 0; k < 4; k++) begin
			for (i = 0; i < 8; i = i + (1 << k)) begin
				a = rand_load_addr(3'd3, 1'b0) | 32'(i);
				issue_requests(1'b0, '0, 1'b1, a, 3'(k));
			end
		end
		close_test();

		begin_test("same_cycle");
		a = rand_load_addr(3'd2, 1'b0);
		first_ar_len = 8'hff;
		watch_ar = 1'b1;
		issue_requests(1'b1, rand_fetch_addr(1'b0), 1'b1, a, 3'd2);
		wait_drained();
		check_value("first AR length", 8'd0, first_ar_len);
		check_value("first AR address", a - (a % 8), first_ar_addr);
		check_value("first AR size", 3'd2, first_ar_size);
		close_test();

		begin_test("error_response");
		issue_requests(1'b1, rand_fetch_addr(1'b1), 1'b0, '0, '0);
		issue_requests(1'b0, '0, 1'b1, rand_load_addr(3'd3, 1'b1), 3'd3);
		issue_requests(1'b1, rand_fetch_addr(1'b0), 1'b0, '0, '0);
		issue_requests(1'b0, '0, 1'b1, rand_load_addr(3'd1, 1'b0), 3'd1);
		close_test();

		begin_test("response_stall");
		stall_resp = 1'b1;
		for (i = 0; i < 4; i++) begin
			k = $urandom_range(0, 3);
			issue_requests(1'b1, rand_fetch_addr(1'b0), 1'b1, rand_load_addr(3'(k), 1'b0), 3'(k));
		end
		close_test();

		begin_test("random_mix");
		for (i = 0; i < 30; i++) begin
			kind = $urandom_range(0, 2);
			k = $urandom_range(0, 3);
			issue_requests(kind != 1, rand_fetch_addr($urandom_range(0, 7) == 0),
				kind != 0, rand_load_addr(3'(k), $urandom_range(0, 7) == 0), 3'(k));
		end
		close_test();
		stall_resp = 1'b0;

		$display("%0d tests finished, %0d checks, %0d errors", n_tests, checks, errors);
		if (errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// ==== dv/tb_axi_mem_model.sv ====
module tb_axi_mem_model (
	input  logic                    clk,
	input  logic                    arst_n,
	input  logic                    ar_valid,
	input  cpu_axi_read_pkg::addr_t ar_addr,
	input  cpu_axi_read_pkg::len_t  ar_len,
	output logic                    ar_ready,
	output logic                    r_valid,
	output cpu_axi_read_pkg::data_t r_data,
	output cpu_axi_read_pkg::resp_t r_resp,
	output logic                    r_last,
	input  logic                    r_ready
);

	cpu_axi_read_pkg::addr_t beat_addr;
	int                      beats_left;
	logic                    busy;
	logic                    took;

	// Handshakes are seen on the rising edge, new outputs go out on the falling edge
	initial begin
		ar_ready   = 1'b0;
		r_valid    = 1'b0;
		r_data     = '0;
		r_resp     = cpu_axi_read_pkg::RESP_OKAY;
		r_last     = 1'b0;
		busy       = 1'b0;
		took       = 1'b0;
		beat_addr  = '0;
		beats_left = 0;
		forever begin
			@(posedge clk);
			took = r_valid && r_ready;
			if (!arst_n) begin
				busy = 1'b0;
			end else if (!busy && ar_valid && ar_ready) begin
				busy       = 1'b1;
				beat_addr  = {ar_addr[31:3], 3'b000};
				beats_left = int'(ar_len) + 1;
			end else if (took) begin
				beat_addr  = beat_addr + 32'd8;
				beats_left = beats_left - 1;
				busy       = (beats_left != 0);
			end
			@(negedge clk);
			ar_ready = !busy && ($urandom_range(0, 2) == 0);
			// A beat on offer stays until the reader takes it
			if (!r_valid || took) begin
				r_valid = busy && ($urandom_range(0, 2) != 0);
			end
			r_data = {beat_addr, ~beat_addr};
			r_resp = beat_addr[31] ? cpu_axi_read_pkg::RESP_SLVERR : cpu_axi_read_pkg::RESP_OKAY;
			r_last = (beats_left == 1);
		end
	end

endmodule

// ==== logic/cpu_axi_read_top.sv ====
module cpu_axi_read_top #(
	parameter int LINE_BEATS = 4
) (
	input  logic                      clk,
	input  logic                      arst_n,
	input  logic                      fetch_req_valid,
	input  cpu_axi_read_pkg::addr_t   fetch_req_addr,
	output logic                      fetch_req_ready,
	output logic                      fetch_line_valid,
	output logic [LINE_BEATS*64-1:0]  fetch_line_data,
	output logic                      fetch_line_err,
	input  logic                      fetch_line_ready,
	input  logic                      load_req_valid,
	input  cpu_axi_read_pkg::addr_t   load_req_addr,
	input  cpu_axi_read_pkg::size_t   load_req_size,
	output logic                      load_req_ready,
	output logic                      load_resp_valid,
	output cpu_axi_read_pkg::data_t   load_resp_data,
	output logic                      load_resp_err,
	input  logic                      load_resp_ready,
	output logic                      ar_valid,
	output cpu_axi_read_pkg::addr_t   ar_addr,
	output cpu_axi_read_pkg::len_t    ar_len,
	output cpu_axi_read_pkg::size_t   ar_size,
	input  logic                      ar_ready,
	input  logic                      r_valid,
	input  cpu_axi_read_pkg::data_t   r_data,
	input  cpu_axi_read_pkg::resp_t   r_resp,
	input  logic                      r_last,
	output logic                      r_ready
);

	// Fetch side of the arbiter
	logic                    f_ar_valid;
	cpu_axi_read_pkg::addr_t f_ar_addr;
	cpu_axi_read_pkg::len_t  f_ar_len;
	cpu_axi_read_pkg::size_t f_ar_size;
	logic                    f_ar_ready;
	logic                    f_r_valid;
	cpu_axi_read_pkg::data_t f_r_data;
	cpu_axi_read_pkg::resp_t f_r_resp;
	logic                    f_r_last;
	logic                    f_r_ready;

	// Load side of the arbiter
	logic                    l_ar_valid;
	cpu_axi_read_pkg::addr_t l_ar_addr;
	cpu_axi_read_pkg::len_t  l_ar_len;
	cpu_axi_read_pkg::size_t l_ar_size;
	logic                    l_ar_ready;
	logic                    l_r_valid;
	cpu_axi_read_pkg::data_t l_r_data;
	cpu_axi_read_pkg::resp_t l_r_resp;
	logic                    l_r_last;
	logic                    l_r_ready;

	fetch_line_reader #(
		.LINE_BEATS(LINE_BEATS)
	) u_fetch (
		.clk              (clk),
		.arst_n           (arst_n),
		.fetch_req_valid  (fetch_req_valid),
		.fetch_req_addr   (fetch_req_addr),
		.fetch_req_ready  (fetch_req_ready),
		.fetch_line_valid (fetch_line_valid),
		.fetch_line_data  (fetch_line_data),
		.fetch_line_err   (fetch_line_err),
		.fetch_line_ready (fetch_line_ready),
		.ar_valid         (f_ar_valid),
		.ar_addr          (f_ar_addr),
		.ar_len           (f_ar_len),
		.ar_size          (f_ar_size),
		.ar_ready         (f_ar_ready),
		.r_valid          (f_r_valid),
		.r_data           (f_r_data),
		.r_resp           (f_r_resp),
		.r_last           (f_r_last),
		.r_ready          (f_r_ready)
	);

	load_reader u_load (
		.clk             (clk),
		.arst_n          (arst_n),
		.load_req_valid  (load_req_valid),
		.load_req_addr   (load_req_addr),
		.load_req_size   (load_req_size),
		.load_req_ready  (load_req_ready),
		.load_resp_valid (load_resp_valid),
		.load_resp_data  (load_resp_data),
		.load_resp_err   (load_resp_err),
		.load_resp_ready (load_resp_ready),
		.ar_valid        (l_ar_valid),
		.ar_addr         (l_ar_addr),
		.ar_len          (l_ar_len),
		.ar_size         (l_ar_size),
		.ar_ready        (l_ar_ready),
		.r_valid         (l_r_valid),
		.r_data          (l_r_data),
		.r_resp          (l_r_resp),
		.r_last          (l_r_last),
		.r_ready         (l_r_ready)
	);

	axi_read_arbiter u_arbiter (
		.clk            (clk),
		.arst_n         (arst_n),
		.fetch_ar_valid (f_ar_valid),
		.fetch_ar_addr  (f_ar_addr),
		.fetch_ar_len   (f_ar_len),
		.fetch_ar_size  (f_ar_size),
		.fetch_r_ready  (f_r_ready),
		.load_ar_valid  (l_ar_valid),
		.load_ar_addr   (l_ar_addr),
		.load_ar_len    (l_ar_len),
		.load_ar_size   (l_ar_size),
		.load_r_ready   (l_r_ready),
		.ar_ready       (ar_ready),
		.r_valid        (r_valid),
		.r_data         (r_data),
		.r_resp         (r_resp),
		.r_last         (r_last),
		.fetch_ar_ready (f_ar_ready),
		.fetch_r_valid  (f_r_valid),
		.fetch_r_data   (f_r_data),
		.fetch_r_resp   (f_r_resp),
		.fetch_r_last   (f_r_last),
		.load_ar_ready  (l_ar_ready),
		.load_r_valid   (l_r_valid),
		.load_r_data    (l_r_data),
		.load_r_resp    (l_r_resp),
		.load_r_last    (l_r_last),
		.ar_valid       (ar_valid),
		.ar_addr        (ar_addr),
		.ar_len         (ar_len),
		.ar_size        (ar_size),
		.r_ready        (r_ready)
	);

endmodule

// ==== logic/axi_read_arbiter.sv ====
module axi_read_arbiter (
	input  logic                      clk,
	input  logic                      arst_n,
	input  logic                      fetch_ar_valid,
	input  cpu_axi_read_pkg::addr_t   fetch_ar_addr,
	input  cpu_axi_read_pkg::len_t    fetch_ar_len,
	input  cpu_axi_read_pkg::size_t   fetch_ar_size,
	input  logic                      fetch_r_ready,
	input  logic                      load_ar_valid,
	input  cpu_axi_read_pkg::addr_t   load_ar_addr,
	input  cpu_axi_read_pkg::len_t    load_ar_len,
	input  cpu_axi_read_pkg::size_t   load_ar_size,
	input  logic                      load_r_ready,
	input  logic                      ar_ready,
	input  logic                      r_valid,
	input  cpu_axi_read_pkg::data_t   r_data,
	input  cpu_axi_read_pkg::resp_t   r_resp,
	input  logic                      r_last,
	output logic                      fetch_ar_ready,
	output logic                      fetch_r_valid,
	output cpu_axi_read_pkg::data_t   fetch_r_data,
	output cpu_axi_read_pkg::resp_t   fetch_r_resp,
	output logic                      fetch_r_last,
	output logic                      load_ar_ready,
	output logic                      load_r_valid,
	output cpu_axi_read_pkg::data_t   load_r_data,
	output cpu_axi_read_pkg::resp_t   load_r_resp,
	output logic                      load_r_last,
	output logic                      ar_valid,
	output cpu_axi_read_pkg::addr_t   ar_addr,
	output cpu_axi_read_pkg::len_t    ar_len,
	output cpu_axi_read_pkg::size_t   ar_size,
	output logic                      r_ready
);

	cpu_axi_read_pkg::arb_state_e owner;
	logic                         last_beat_done;

	assign last_beat_done = r_valid && r_ready && r_last;

	// The grant stays with one reader until its last beat is taken
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			owner <= cpu_axi_read_pkg::ARB_IDLE;
		end else begin
			case (owner)
				cpu_axi_read_pkg::ARB_IDLE: begin
					// Loads win a tie since they stall the pipeline longer
					if (load_ar_valid) begin
						owner <= cpu_axi_read_pkg::ARB_LOAD;
					end else if (fetch_ar_valid) begin
						owner <= cpu_axi_read_pkg::ARB_FETCH;
					end
				end
				cpu_axi_read_pkg::ARB_FETCH,
				cpu_axi_read_pkg::ARB_LOAD: begin
					if (last_beat_done) begin
						owner <= cpu_axi_read_pkg::ARB_IDLE;
					end
				end
				default: owner <= cpu_axi_read_pkg::ARB_IDLE;
			endcase
		end
	end

	always_comb begin
		ar_valid       = 1'b0;
		ar_addr        = '0;
		ar_len         = '0;
		ar_size        = '0;
		r_ready        = 1'b0;
		fetch_ar_ready = 1'b0;
		load_ar_ready  = 1'b0;
		fetch_r_valid  = 1'b0;
		fetch_r_data   = '0;
		fetch_r_resp   = cpu_axi_read_pkg::RESP_OKAY;
		fetch_r_last   = 1'b0;
		load_r_valid   = 1'b0;
		load_r_data    = '0;
		load_r_resp    = cpu_axi_read_pkg::RESP_OKAY;
		load_r_last    = 1'b0;
		case (owner)
			cpu_axi_read_pkg::ARB_FETCH: begin
				ar_valid       = fetch_ar_valid;
				ar_addr        = fetch_ar_addr;
				ar_len         = fetch_ar_len;
				ar_size        = fetch_ar_size;
				r_ready        = fetch_r_ready;
				fetch_ar_ready = ar_ready;
				fetch_r_valid  = r_valid;
				fetch_r_data   = r_data;
				fetch_r_resp   = r_resp;
				fetch_r_last   = r_last;
			end
			cpu_axi_read_pkg::ARB_LOAD: begin
				ar_valid      = load_ar_valid;
				ar_addr       = load_ar_addr;
				ar_len        = load_ar_len;
				ar_size       = load_ar_size;
				r_ready       = load_r_ready;
				load_ar_ready = ar_ready;
				load_r_valid  = r_valid;
				load_r_data   = r_data;
				load_r_resp   = r_resp;
				load_r_last   = r_last;
			end
			default: ;
		endcase
	end

endmodule

// ==== lsu/load_reader.sv ====
module load_reader (
	input  logic                      clk,
	input  logic                      arst_n,
	input  logic                      load_req_valid,
	input  cpu_axi_read_pkg::addr_t   load_req_addr,
	input  cpu_axi_read_pkg::size_t   load_req_size,
	output logic                      load_req_ready,
	output logic                      load_resp_valid,
	output cpu_axi_read_pkg::data_t   load_resp_data,
	output logic                      load_resp_err,
	input  logic                      load_resp_ready,
	output logic                      ar_valid,
	output cpu_axi_read_pkg::addr_t   ar_addr,
	output cpu_axi_read_pkg::len_t    ar_len,
	output cpu_axi_read_pkg::size_t   ar_size,
	input  logic                      ar_ready,
	input  logic                      r_valid,
	input  cpu_axi_read_pkg::data_t   r_data,
	input  cpu_axi_read_pkg::resp_t   r_resp,
	input  logic                      r_last,
	output logic                      r_ready
);

	cpu_axi_read_pkg::load_state_e state;
	cpu_axi_read_pkg::addr_t       req_addr;
	cpu_axi_read_pkg::size_t       req_size;
	cpu_axi_read_pkg::data_t       shifted;
	cpu_axi_read_pkg::data_t       extracted;
	logic                          err_flag;
	logic                          beat_fire;

	assign load_req_ready  = (state == cpu_axi_read_pkg::LOAD_IDLE);
	assign load_resp_valid = (state == cpu_axi_read_pkg::LOAD_DONE);
	assign load_resp_err   = err_flag;
	assign ar_valid        = (state == cpu_axi_read_pkg::LOAD_AR);
	assign ar_addr         = {req_addr[31:3], 3'b000};
	assign ar_len          = '0;
	assign ar_size         = req_size;
	assign r_ready         = (state == cpu_axi_read_pkg::LOAD_DATA);
	assign beat_fire       = r_valid && r_ready;

	// Move the addressed bytes down to bit 0, then clear everything above the size
	assign shifted = r_data >> {req_addr[2:0], 3'b000};

	always_comb begin
		case (req_size)
			3'd0:    extracted = {56'b0, shifted[7:0]};
			3'd1:    extracted = {48'b0, shifted[15:0]};
			3'd2:    extracted = {32'b0, shifted[31:0]};
			default: extracted = shifted;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state    <= cpu_axi_read_pkg::LOAD_IDLE;
			err_flag <= 1'b0;
		end else begin
			case (state)
				cpu_axi_read_pkg::LOAD_IDLE: begin
					if (load_req_valid) begin
						state    <= cpu_axi_read_pkg::LOAD_AR;
						err_flag <= 1'b0;
					end
				end
				cpu_axi_read_pkg::LOAD_AR: begin
					if (ar_ready) begin
						state <= cpu_axi_read_pkg::LOAD_DATA;
					end
				end
				cpu_axi_read_pkg::LOAD_DATA: begin
					if (beat_fire) begin
						err_flag <= (r_resp != cpu_axi_read_pkg::RESP_OKAY);
						if (r_last) begin
							state <= cpu_axi_read_pkg::LOAD_DONE;
						end
					end
				end
				cpu_axi_read_pkg::LOAD_DONE: begin
					if (load_resp_ready) begin
						state <= cpu_axi_read_pkg::LOAD_IDLE;
					end
				end
				default: state <= cpu_axi_read_pkg::LOAD_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (load_req_ready && load_req_valid) begin
			req_addr <= load_req_addr;
			req_size <= load_req_size;
		end
		if (beat_fire) begin
			load_resp_data <= extracted;
		end
	end

endmodule

// ==== fetch/fetch_line_reader.sv ====
module fetch_line_reader #(
	parameter int LINE_BEATS = 4
) (
	input  logic                      clk,
	input  logic                      arst_n,
	input  logic                      fetch_req_valid,
	input  cpu_axi_read_pkg::addr_t   fetch_req_addr,
	output logic                      fetch_req_ready,
	output logic                      fetch_line_valid,
	output logic [LINE_BEATS*64-1:0]  fetch_line_data,
	output logic                      fetch_line_err,
	input  logic                      fetch_line_ready,
	output logic                      ar_valid,
	output cpu_axi_read_pkg::addr_t   ar_addr,
	output cpu_axi_read_pkg::len_t    ar_len,
	output cpu_axi_read_pkg::size_t   ar_size,
	input  logic                      ar_ready,
	input  logic                      r_valid,
	input  cpu_axi_read_pkg::data_t   r_data,
	input  cpu_axi_read_pkg::resp_t   r_resp,
	input  logic                      r_last,
	output logic                      r_ready
);

	localparam int BEAT_IDX_W = (LINE_BEATS > 1) ? $clog2(LINE_BEATS) : 1;
	localparam int LINE_OFS_W = $clog2(LINE_BEATS * 8);

	cpu_axi_read_pkg::fetch_state_e state;
	cpu_axi_read_pkg::addr_t        line_addr;
	cpu_axi_read_pkg::data_t        line_buf [LINE_BEATS];
	logic [BEAT_IDX_W-1:0]          beat_idx;
	logic                           err_flag;
	logic                           beat_fire;

	assign fetch_req_ready  = (state == cpu_axi_read_pkg::FETCH_IDLE);
	assign fetch_line_valid = (state == cpu_axi_read_pkg::FETCH_DONE);
	assign fetch_line_err   = err_flag;
	assign ar_valid         = (state == cpu_axi_read_pkg::FETCH_AR);
	assign ar_addr          = line_addr;
	assign ar_len           = cpu_axi_read_pkg::len_t'(LINE_BEATS - 1);
	assign ar_size          = cpu_axi_read_pkg::SIZE_8B;
	assign r_ready          = (state == cpu_axi_read_pkg::FETCH_DATA);
	assign beat_fire        = r_valid && r_ready;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state    <= cpu_axi_read_pkg::FETCH_IDLE;
			beat_idx <= '0;
			err_flag <= 1'b0;
		end else begin
			case (state)
				cpu_axi_read_pkg::FETCH_IDLE: begin
					if (fetch_req_valid) begin
						state    <= cpu_axi_read_pkg::FETCH_AR;
						beat_idx <= '0;
						err_flag <= 1'b0;
					end
				end
				cpu_axi_read_pkg::FETCH_AR: begin
					if (ar_ready) begin
						state <= cpu_axi_read_pkg::FETCH_DATA;
					end
				end
				cpu_axi_read_pkg::FETCH_DATA: begin
					if (beat_fire) begin
						beat_idx <= beat_idx + 1'b1;
						// Any bad beat marks the whole line
						if (r_resp != cpu_axi_read_pkg::RESP_OKAY) begin
							err_flag <= 1'b1;
						end
						if (r_last) begin
							state <= cpu_axi_read_pkg::FETCH_DONE;
						end
					end
				end
				cpu_axi_read_pkg::FETCH_DONE: begin
					if (fetch_line_ready) begin
						state <= cpu_axi_read_pkg::FETCH_IDLE;
					end
				end
				default: state <= cpu_axi_read_pkg::FETCH_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (fetch_req_ready && fetch_req_valid) begin
			line_addr <= {fetch_req_addr[31:LINE_OFS_W], {LINE_OFS_W{1'b0}}};
		end
		if (beat_fire) begin
			line_buf[beat_idx] <= r_data;
		end
	end

	// Beat 0 lands in the low bits of the line
	for (genvar i = 0; i < LINE_BEATS; i++) begin : g_line
		assign fetch_line_data[i*64 +: 64] = line_buf[i];
	end

endmodule

// ==== common/cpu_axi_read_pkg.sv ====
package cpu_axi_read_pkg;

	typedef logic [31:0] addr_t;
	typedef logic [63:0] data_t;
	typedef logic [7:0]  len_t;
	typedef logic [2:0]  size_t;
	typedef logic [1:0]  resp_t;

	// AXI4 read response codes
	localparam resp_t RESP_OKAY   = 2'b00;
	localparam resp_t RESP_SLVERR = 2'b10;
	localparam resp_t RESP_DECERR = 2'b11;

	// Size code for a full 64-bit beat
	localparam size_t SIZE_8B = 3'b011;

	typedef enum logic [1:0] {
		ARB_IDLE  = 2'd0,
		ARB_FETCH = 2'd1,
		ARB_LOAD  = 2'd2
	} arb_state_e;

	typedef enum logic [1:0] {
		FETCH_IDLE = 2'd0,
		FETCH_AR   = 2'd1,
		FETCH_DATA = 2'd2,
		FETCH_DONE = 2'd3
	} fetch_state_e;

	typedef enum logic [1:0] {
		LOAD_IDLE = 2'd0,
		LOAD_AR   = 2'd1,
		LOAD_DATA = 2'd2,
		LOAD_DONE = 2'd3
	} load_state_e;

endpackage
